//--- Makefile
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, fail unless the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
logic/dcache_cfg_pkg.sv
logic/dcache_bus_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

//--- logic/dcache_bus_pkg.sv
/*
  cpu port and memory bus structs
  bursts are always two beats, low half of the line first
  the bus has valid, beat strobe and last only, no handshake
*/
`default_nettype none

package dcache_bus_pkg;

    // size codes, bytes = 1 << size
    localparam logic [1:0] SIZE_B = 2'd0;
    localparam logic [1:0] SIZE_H = 2'd1;
    localparam logic [1:0] SIZE_W = 2'd2;
    localparam logic [1:0] SIZE_D = 2'd3;

    localparam int HIT_CNT_W = 32;

    typedef struct packed {
        logic                              valid;
        logic                              write;  // 1 store, 0 load
        logic [1:0]                        size;
        logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
        logic [dcache_cfg_pkg::BEAT_W-1:0] wdata;  // lsb aligned
    } cpu_req_t;

    typedef struct packed {
        logic                              valid;
        logic [dcache_cfg_pkg::ADDR_W-1:0] addr;   // line aligned
    } mem_rd_req_t;

    typedef struct packed {
        logic                              strobe; // one beat this cycle
        logic                              last;
        logic [dcache_cfg_pkg::BEAT_W-1:0] data;
    } mem_rd_rsp_t;

    typedef struct packed {
        logic                              valid;
        logic [dcache_cfg_pkg::ADDR_W-1:0] addr;
        logic [dcache_cfg_pkg::BEAT_W-1:0] data;   // current beat
    } mem_wr_req_t;

    typedef struct packed {
        logic strobe;  // beat consumed
        logic last;
    } mem_wr_rsp_t;

endpackage

`default_nettype wire

//--- logic/dcache_cfg_pkg.sv
/*
  geometry of the 8 KB, 4-way data cache, 16-byte lines over 128 sets
  the address word is decoded as tag/index/offset or as line/offset
  accesses are naturally aligned, nothing here checks that
*/
`default_nettype none

package dcache_cfg_pkg;

    localparam int WAYS       = 4;
    localparam int SETS       = 128;
    localparam int LINE_BYTES = 16;
    localparam int OFF_W      = 4;   // log2 of LINE_BYTES
    localparam int IDX_W      = 7;   // log2 of SETS
    localparam int TAG_W      = 21;
    localparam int AGE_W      = 2;   // saturating age counter
    localparam int ADDR_W     = 32;
    localparam int BEAT_W     = 64;  // two beats per line

    typedef logic [LINE_BYTES*8-1:0] line_t;
    typedef logic [1:0]              way_t;

    // lookup view
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFF_W-1:0] off;
    } addr_tio_t;

    // bus view, line number gives the aligned burst address
    typedef struct packed {
        logic [ADDR_W-OFF_W-1:0] line;
        logic [OFF_W-1:0]        off;
    } addr_line_t;

    typedef union packed {
        addr_tio_t  tio;
        addr_line_t lo;
    } dcache_addr_u;

endpackage

`default_nettype wire

//--- logic/dcache_ctrl.sv
/*
  lookup/refill FSM plus a separate write-back FSM that runs alongside
  a hit answers 2 cycles after accept
  misses wait for the last read beat and for any write-back in flight
  store misses add one merge cycle
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_req_t              cpu_req_i,
    output logic [BEAT_W-1:0]     cpu_rdata_o,
    output logic                  cpu_ready_o,
    output mem_rd_req_t           rd_req_o,
    input  mem_rd_rsp_t           rd_rsp_i,
    output mem_wr_req_t           wr_req_o,
    input  mem_wr_rsp_t           wr_rsp_i,
    output logic [HIT_CNT_W-1:0]  hit_count_o,
    output logic [HIT_CNT_W-1:0]  miss_count_o,
    output dcache_addr_u          lookup_addr_o,
    output logic                  touch_o,
    output logic                  fill_o,
    output logic                  fill_dirty_o,
    output logic                  mark_dirty_o,
    output way_t                  way_o,
    input  logic                  hit_i,
    input  way_t                  hit_way_i,
    input  way_t                  victim_way_i,
    input  logic [TAG_W-1:0]      victim_tag_i,
    input  logic                  victim_dirty_i,
    output logic [IDX_W-1:0]      rd_set_o,
    output logic                  wr_en_o,
    output way_t                  wr_way_o,
    output logic [LINE_BYTES-1:0] wr_be_o,
    output line_t                 wr_line_o,
    input  line_t [WAYS-1:0]      rd_lines_i
);

    typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, MERGE, RESPOND} state_e;
    typedef enum logic [1:0] {WB_IDLE, WB_LO, WB_HI} wb_state_e;

    state_e                 state_q;
    wb_state_e              wb_q;
    cpu_req_t               req_q;
    way_t                   vway_q;       // way picked for the refill
    logic [BEAT_W-1:0]      refill_lo_q;
    logic [BEAT_W-1:0]      rdata_q;
    logic [ADDR_W-1:0]      wb_addr_q;
    line_t                  wb_line_q;    // victim copy kept apart from the refill
    logic [HIT_CNT_W-1:0]   hit_cnt_q;
    logic [HIT_CNT_W-1:0]   miss_cnt_q;

    dcache_addr_u           in_addr;
    dcache_addr_u           req_addr;
    logic [LINE_BYTES-1:0]  req_be;
    line_t                  req_line;
    line_t                  refill_line;
    logic                   beat_last;
    logic                   wb_start;
    logic                   wb_busy;

    function automatic logic [7:0] size_be(logic [1:0] size);
        case (size)
            SIZE_B:  return 8'h01;
            SIZE_H:  return 8'h03;
            SIZE_W:  return 8'h0f;
            SIZE_D:  return 8'hff;
            default: return 8'h00;
        endcase
    endfunction

    // pick the half, shift the bytes down, zero the rest
    function automatic logic [BEAT_W-1:0] load_align(line_t line, logic [OFF_W-1:0] off,
                                                     logic [1:0] size);
        logic [BEAT_W-1:0] half;
        logic [BEAT_W-1:0] mask;
        logic [7:0]        be;
        half = off[OFF_W-1] ? line[2*BEAT_W-1:BEAT_W] : line[BEAT_W-1:0];
        be   = size_be(size);
        for (int b = 0; b < 8; b++) mask[b*8 +: 8] = {8{be[b]}};
        return (half >> {off[2:0], 3'b000}) & mask;
    endfunction

    assign in_addr     = cpu_req_i.addr;
    assign req_addr    = req_q.addr;
    assign req_be      = LINE_BYTES'(size_be(req_q.size)) << req_addr.tio.off;
    assign req_line    = line_t'(req_q.wdata) << {req_addr.tio.off, 3'b000};
    assign refill_line = {rd_rsp_i.data, refill_lo_q};  // valid on the last beat
    assign beat_last   = state_q == REFILL && rd_rsp_i.strobe && rd_rsp_i.last;
    assign wb_start    = state_q == LOOKUP && !hit_i && victim_dirty_i;
    assign wb_busy     = wb_q != WB_IDLE;

    // tag store side
    assign lookup_addr_o = req_addr;
    assign touch_o       = state_q == LOOKUP && hit_i;
    assign mark_dirty_o  = touch_o && req_q.write;
    assign fill_o        = beat_last;
    assign fill_dirty_o  = req_q.write;  // the merge follows right after
    assign way_o         = (state_q == LOOKUP) ? hit_way_i : vway_q;

    // data store read launches on the accepting edge
    assign rd_set_o  = (state_q == IDLE) ? in_addr.tio.idx : req_addr.tio.idx;
    assign wr_en_o   = mark_dirty_o || beat_last || state_q == MERGE;
    assign wr_way_o  = way_o;
    assign wr_be_o   = beat_last ? '1 : req_be;
    assign wr_line_o = beat_last ? refill_line : req_line;

    // bus side
    assign rd_req_o.valid = state_q == REFILL;  // falls after the last beat
    assign rd_req_o.addr  = {req_addr.lo.line, OFF_W'(0)};
    assign wr_req_o.valid = wb_busy;
    assign wr_req_o.addr  = wb_addr_q;
    assign wr_req_o.data  = (wb_q == WB_HI) ? wb_line_q[2*BEAT_W-1:BEAT_W] : wb_line_q[BEAT_W-1:0];

    assign cpu_ready_o  = state_q == RESPOND && !wb_busy;
    assign cpu_rdata_o  = rdata_q;
    assign hit_count_o  = hit_cnt_q;
    assign miss_count_o = miss_cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            hit_cnt_q  <= '0;
            miss_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE:    if (cpu_req_i.valid) state_q <= LOOKUP;
                LOOKUP: begin  // compare cycle counts one hit or miss per request
                    if (hit_i) begin
                        state_q   <= RESPOND;
                        hit_cnt_q <= hit_cnt_q + 1'b1;
                    end else begin
                        state_q    <= REFILL;
                        miss_cnt_q <= miss_cnt_q + 1'b1;
                    end
                end
                REFILL:  if (beat_last) state_q <= req_q.write ? MERGE : RESPOND;
                MERGE:   state_q <= RESPOND;
                RESPOND: if (!wb_busy) state_q <= IDLE;  // hold until write-back drains
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) req_q <= cpu_req_i;  // held steady by the cpu
        if (state_q == LOOKUP) begin
            vway_q  <= victim_way_i;
            rdata_q <= load_align(rd_lines_i[hit_way_i], req_addr.tio.off, req_q.size);
        end
        if (state_q == REFILL && rd_rsp_i.strobe) begin
            if (rd_rsp_i.last) rdata_q <= load_align(refill_line, req_addr.tio.off, req_q.size);
            else refill_lo_q <= rd_rsp_i.data;
        end
        if (wb_start) begin
            wb_line_q <= rd_lines_i[victim_way_i];
            wb_addr_q <= {victim_tag_i, req_addr.tio.idx, OFF_W'(0)};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q <= WB_IDLE;
        end else begin
            case (wb_q)
                WB_IDLE: if (wb_start) wb_q <= WB_LO;  // same edge as the refill request
                WB_LO:   if (wr_rsp_i.strobe) wb_q <= WB_HI;
                WB_HI:   if (wr_rsp_i.strobe && wr_rsp_i.last) wb_q <= WB_IDLE;
                default: wb_q <= WB_IDLE;
            endcase
        end
    end

    // read request stays up and ready stays low until the beat with last
    a_no_ready_in_refill: assert property (@(posedge clk) disable iff (rst)
        rd_req_o.valid && !(rd_rsp_i.strobe && rd_rsp_i.last)
        |=> rd_req_o.valid && !cpu_ready_o);

    // previous write-back always drains before the next miss is compared
    a_wb_single: assert property (@(posedge clk) disable iff (rst)
        wb_start |-> wb_q == WB_IDLE);

endmodule

`default_nettype wire

//--- logic/dcache_data_store.sv
/*
  line data for all ways, one array per way, no reset on contents
  read of every way in the set is registered, one cycle latency
  writes are byte enabled and land on the edge
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_data_store
    import dcache_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic [IDX_W-1:0]      rd_set_i,
    input  logic                  wr_en_i,
    input  way_t                  wr_way_i,
    input  logic [IDX_W-1:0]      wr_set_i,
    input  logic [LINE_BYTES-1:0] wr_be_i,
    input  line_t                 wr_line_i,
    output line_t [WAYS-1:0]      rd_lines_o
);

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        line_t mem [SETS];
        line_t rd_q;

        always_ff @(posedge clk) begin
            if (wr_en_i && wr_way_i == way_t'(w)) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (wr_be_i[b]) mem[wr_set_i][b*8 +: 8] <= wr_line_i[b*8 +: 8];
                end
            end
            rd_q <= mem[rd_set_i];  // old data on a same-cycle write
        end

        assign rd_lines_o[w] = rd_q;
    end

    // every write from the controller carries at least one byte
    a_be_nonzero: assert property (@(posedge clk) wr_en_i |-> wr_be_i != '0);

endmodule

`default_nettype wire

//--- logic/dcache_tag_store.sv
/*
  tag, valid, dirty and age arrays in flops, reads are combinational
  victim is the lowest way with the highest age, invalid ways get no priority
  updates land on the next edge
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_store
    import dcache_cfg_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  dcache_addr_u     lookup_addr_i,
    input  logic             touch_i,       // hit on way_i
    input  logic             fill_i,        // refill into way_i
    input  logic             fill_dirty_i,
    input  logic             mark_dirty_i,
    input  way_t             way_i,
    output logic             hit_o,
    output way_t             hit_way_o,
    output way_t             victim_way_o,
    output logic [TAG_W-1:0] victim_tag_o,
    output logic             victim_dirty_o
);

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [TAG_W-1:0] tag_q   [SETS][WAYS];
    logic [AGE_W-1:0] age_q   [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];
    logic [WAYS-1:0]  dirty_q [SETS];

    logic [IDX_W-1:0] idx;
    logic [WAYS-1:0]  hit_vec;

    assign idx = lookup_addr_i.tio.idx;

    always_comb begin
        way_t hway;
        way_t best;
        hway = '0;
        best = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_q[idx][w] && (tag_q[idx][w] == lookup_addr_i.tio.tag);
            if (hit_vec[w]) hway = way_t'(w);
            // strict compare keeps the lowest way on a tie
            if (age_q[idx][w] > age_q[idx][best]) best = way_t'(w);
        end
        hit_way_o    = hway;
        victim_way_o = best;
    end

    assign hit_o          = |hit_vec;
    assign victim_tag_o   = tag_q[idx][victim_way_o];
    assign victim_dirty_o = valid_q[idx][victim_way_o] && dirty_q[idx][victim_way_o];

    always_ff @(posedge clk) begin
        if (fill_i) tag_q[idx][way_i] <= lookup_addr_i.tio.tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                for (int w = 0; w < WAYS; w++) age_q[s][w] <= '0;
            end
        end else begin
            if (fill_i) begin
                valid_q[idx][way_i] <= 1'b1;
                dirty_q[idx][way_i] <= fill_dirty_i;  // set when a store merges next
            end else if (mark_dirty_i) begin
                dirty_q[idx][way_i] <= 1'b1;
            end
            if (touch_i || fill_i) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (way_t'(w) == way_i) begin
                        if (fill_i) age_q[idx][w] <= '0;
                        else if (age_q[idx][w] != '0) age_q[idx][w] <= age_q[idx][w] - 1'b1;
                    end else if (age_q[idx][w] != AGE_MAX) begin
                        age_q[idx][w] <= age_q[idx][w] + 1'b1;  // others grow older
                    end
                end
            end
        end
    end

    // two valid ways of one set never hold the same tag
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
/*
  4-way write-back data cache, 8 KB, between a cpu port and a 64-bit bus
  one request at a time, the cpu holds it until the ready pulse
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_top
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_req_t             cpu_req_i,
    output logic [BEAT_W-1:0]    cpu_rdata_o,
    output logic                 cpu_ready_o,
    output mem_rd_req_t          rd_req_o,
    input  mem_rd_rsp_t          rd_rsp_i,
    output mem_wr_req_t          wr_req_o,
    input  mem_wr_rsp_t          wr_rsp_i,
    output logic [HIT_CNT_W-1:0] hit_count_o,
    output logic [HIT_CNT_W-1:0] miss_count_o
);

    // controller to tag store
    dcache_addr_u          lookup_addr;
    logic                  touch;
    logic                  fill;
    logic                  fill_dirty;
    logic                  mark_dirty;
    way_t                  tag_way;
    logic                  hit;
    way_t                  hit_way;
    way_t                  victim_way;
    logic [TAG_W-1:0]      victim_tag;
    logic                  victim_dirty;

    // controller to data store
    logic [IDX_W-1:0]      rd_set;  // also the write set
    logic                  wr_en;
    way_t                  wr_way;
    logic [LINE_BYTES-1:0] wr_be;
    line_t                 wr_line;
    line_t [WAYS-1:0]      rd_lines;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_i      (cpu_req_i),
        .cpu_rdata_o    (cpu_rdata_o),
        .cpu_ready_o    (cpu_ready_o),
        .rd_req_o       (rd_req_o),
        .rd_rsp_i       (rd_rsp_i),
        .wr_req_o       (wr_req_o),
        .wr_rsp_i       (wr_rsp_i),
        .hit_count_o    (hit_count_o),
        .miss_count_o   (miss_count_o),
        .lookup_addr_o  (lookup_addr),
        .touch_o        (touch),
        .fill_o         (fill),
        .fill_dirty_o   (fill_dirty),
        .mark_dirty_o   (mark_dirty),
        .way_o          (tag_way),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_tag_i   (victim_tag),
        .victim_dirty_i (victim_dirty),
        .rd_set_o       (rd_set),
        .wr_en_o        (wr_en),
        .wr_way_o       (wr_way),
        .wr_be_o        (wr_be),
        .wr_line_o      (wr_line),
        .rd_lines_i     (rd_lines)
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .lookup_addr_i  (lookup_addr),
        .touch_i        (touch),
        .fill_i         (fill),
        .fill_dirty_i   (fill_dirty),
        .mark_dirty_i   (mark_dirty),
        .way_i          (tag_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_tag_o   (victim_tag),
        .victim_dirty_o (victim_dirty)
    );

    dcache_data_store u_data_store (
        .clk        (clk),
        .rd_set_i   (rd_set),
        .wr_en_i    (wr_en),
        .wr_way_i   (wr_way),
        .wr_set_i   (rd_set),  // writes only happen once the request set is held
        .wr_be_i    (wr_be),
        .wr_line_i  (wr_line),
        .rd_lines_o (rd_lines)
    );

endmodule

`default_nettype wire

//--- sim/dcache_checker.sv
/*
  watches the cpu port and both bus channels of the data cache
  expected load data comes from the testbench per request
  a hit must answer 2 cycles after accept
  refill and write-back addresses must be line aligned
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_checker
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  cpu_req_t             cpu_req_i,
    input  logic [BEAT_W-1:0]    cpu_rdata_i,
    input  logic                 cpu_ready_i,
    input  mem_rd_req_t          rd_req_i,
    input  mem_wr_req_t          wr_req_i,
    input  logic [HIT_CNT_W-1:0] hit_count_i,
    input  logic [HIT_CNT_W-1:0] miss_count_i
);

    string                test_name;
    logic                 exp_read;
    logic [BEAT_W-1:0]    exp_data;
    logic                 busy;          // request accepted, waiting for ready
    int                   wait_cycles;
    logic [HIT_CNT_W-1:0] hits_at_accept;
    logic                 rd_seen;
    logic                 wr_seen;
    int                   errors = 0;
    int                   tests_done = 0;

    // called by the driver just before it raises valid
    task automatic expect_result(input string name, input logic is_read,
                                 input logic [BEAT_W-1:0] data);
        test_name = name;
        exp_read  = is_read;
        exp_data  = data;
    endtask

    task automatic finish_test();
        if (exp_read && cpu_rdata_i !== exp_data) begin
            $display("Error: %s expected %h actual %h", test_name, exp_data, cpu_rdata_i);
            errors++;
        end else if (hit_count_i != hits_at_accept && wait_cycles != 2) begin
            $display("%s: hit answered %0d cycles after accept instead of 2", test_name,
                     wait_cycles);
            errors++;
        end else begin
            $display("%s: ok%s", test_name, exp_read ? "" : " (store)");
        end
        tests_done++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            busy    = 1'b0;
            rd_seen = 1'b0;
            wr_seen = 1'b0;
        end else begin
            if (!busy && cpu_req_i.valid && !cpu_ready_i) begin  // accepting edge
                busy           = 1'b1;
                wait_cycles    = 0;
                hits_at_accept = hit_count_i;
            end else if (busy) begin
                wait_cycles++;
                if (cpu_ready_i) begin
                    busy = 1'b0;
                    finish_test();
                end
            end else if (cpu_ready_i) begin
                $display("ready pulse longer than one cycle or without a request");
                errors++;
            end

            // first cycle of a refill burst
            if (rd_req_i.valid && !rd_seen) begin
                if (rd_req_i.addr != {cpu_req_i.addr[ADDR_W-1:OFF_W], OFF_W'(0)}) begin
                    $display("refill address %h is not the aligned line of request %h",
                             rd_req_i.addr, cpu_req_i.addr);
                    errors++;
                end
            end
            rd_seen = rd_req_i.valid;

            // victim goes out under its own line and never the requested one
            if (wr_req_i.valid && !wr_seen) begin
                if (wr_req_i.addr[OFF_W-1:0] != '0 ||
                    wr_req_i.addr[ADDR_W-1:OFF_W] == cpu_req_i.addr[ADDR_W-1:OFF_W]) begin
                    $display("write-back address %h is unaligned or equals the request line",
                             wr_req_i.addr);
                    errors++;
                end
            end
            wr_seen = wr_req_i.valid;
        end
    end

    task automatic close_report(input int exp_hits, input int exp_misses,
                                output int total_errors);
        if (hit_count_i != HIT_CNT_W'(exp_hits)) begin
            $display("Error: hit_count expected %0d actual %0d", exp_hits, hit_count_i);
            errors++;
        end
        if (miss_count_i != HIT_CNT_W'(exp_misses)) begin
            $display("Error: miss_count expected %0d actual %0d", exp_misses, miss_count_i);
            errors++;
        end
        $display("%0d tests, %0d errors, hits %0d, misses %0d", tests_done, errors,
                 hit_count_i, miss_count_i);
        total_errors = errors;
    endtask

endmodule

`default_nettype wire

//--- sim/dcache_tb.sv
/*
  data cache testbench, requests and expected loads come from sim/dcache_trace.txt
  memory is sparse, untouched beats read back as {~addr, addr} of the beat address
  bus beats arrive after 0 to 3 idle cycles, cpu inputs change on the falling edge
*/
`timescale 1ns/1ns
`default_nettype none

module dcache_tb
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 8;
    localparam int MAX_TESTS  = 64;

    logic                 clk;
    logic                 rst;
    cpu_req_t             cpu_req;
    logic [BEAT_W-1:0]    cpu_rdata;
    logic                 cpu_ready;
    mem_rd_req_t          rd_req;
    mem_rd_rsp_t          rd_rsp;
    mem_wr_req_t          wr_req;
    mem_wr_rsp_t          wr_rsp;
    logic [HIT_CNT_W-1:0] hit_count;
    logic [HIT_CNT_W-1:0] miss_count;

    // trace contents
    string                t_name   [MAX_TESTS];
    logic                 t_write  [MAX_TESTS];
    logic [1:0]           t_size   [MAX_TESTS];
    logic [ADDR_W-1:0]    t_addr   [MAX_TESTS];
    logic [BEAT_W-1:0]    t_wdata  [MAX_TESTS];
    logic [BEAT_W-1:0]    t_expect [MAX_TESTS];
    int                   n_tests = 0;
    int                   exp_hits;
    int                   exp_misses;
    logic                 trace_loaded = 1'b0;

    logic [BEAT_W-1:0]    mem [logic [ADDR_W-1:0]];  // keyed by beat address
    int                   seed = 32'h13e6ba34;

    dcache_top dcache_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .cpu_rdata_o  (cpu_rdata),
        .cpu_ready_o  (cpu_ready),
        .rd_req_o     (rd_req),
        .rd_rsp_i     (rd_rsp),
        .wr_req_o     (wr_req),
        .wr_rsp_i     (wr_rsp),
        .hit_count_o  (hit_count),
        .miss_count_o (miss_count)
    );

    dcache_checker checker_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .cpu_rdata_i  (cpu_rdata),
        .cpu_ready_i  (cpu_ready),
        .rd_req_i     (rd_req),
        .wr_req_i     (wr_req),
        .hit_count_i  (hit_count),
        .miss_count_i (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [1:0] size_code(int nbytes);
        case (nbytes)
            1:       return SIZE_B;
            2:       return SIZE_H;
            4:       return SIZE_W;
            default: return SIZE_D;
        endcase
    endfunction

    function automatic logic [BEAT_W-1:0] beat_fetch(logic [ADDR_W-1:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return {~addr, addr};  // never written
    endfunction

    // returns 1 when the file opened and held a counts line
    function automatic logic read_trace();
        int                fd;
        int                n;
        int                nbytes;
        logic              have_counts;
        string             text;
        string             name;
        string             op;
        logic [ADDR_W-1:0] addr;
        logic [BEAT_W-1:0] wdata;
        logic [BEAT_W-1:0] expect_data;
        have_counts = 1'b0;
        fd = $fopen("sim/dcache_trace.txt", "r");
        if (fd == 0) return 1'b0;
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text[0] == "#") continue;  // blank or comment
            n = $sscanf(text, "%s", name);
            if (name == "counts") begin
                n = $sscanf(text, "%s %d %d", name, exp_hits, exp_misses);
                have_counts = (n == 3);
            end else begin
                n = $sscanf(text, "%s %s %d %h %h %h", name, op, nbytes, addr, wdata,
                            expect_data);
                if (n == 6 && n_tests < MAX_TESTS) begin
                    t_name[n_tests]   = name;
                    t_write[n_tests]  = (op == "W");
                    t_size[n_tests]   = size_code(nbytes);
                    t_addr[n_tests]   = addr;
                    t_wdata[n_tests]  = wdata;
                    t_expect[n_tests] = expect_data;
                    n_tests++;
                end
            end
        end
        $fclose(fd);
        return have_counts && n_tests > 0;
    endfunction

    // called on a falling edge, returns on a falling edge
    task automatic run_request(input int i);
        cpu_req.valid = 1'b1;
        cpu_req.write = t_write[i];
        cpu_req.size  = t_size[i];
        cpu_req.addr  = t_addr[i];
        cpu_req.wdata = t_wdata[i];
        checker_inst.expect_result(t_name[i], !t_write[i], t_expect[i]);
        do @(negedge clk); while (!cpu_ready);
        cpu_req.valid = 1'b0;  // drop before the edge that samples ready
        @(negedge clk);
    endtask

    // refill channel, two beats low half first
    initial begin : refill_model
        logic [ADDR_W-1:0] line;
        int                gap;
        forever begin
            @(negedge clk);
            if (!rst && rd_req.valid) begin
                line = rd_req.addr;
                for (int beat = 0; beat < 2; beat++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    rd_rsp.strobe = 1'b1;
                    rd_rsp.last   = (beat == 1);
                    rd_rsp.data   = beat_fetch(line + ADDR_W'(beat * 8));
                    @(negedge clk);
                    rd_rsp = '0;
                end
            end
        end
    end

    // write-back channel, line lands in memory after the last beat
    initial begin : writeback_model
        logic [ADDR_W-1:0] line;
        logic [BEAT_W-1:0] beats [2];
        int                gap;
        forever begin
            @(negedge clk);
            if (!rst && wr_req.valid) begin
                line = wr_req.addr;
                for (int beat = 0; beat < 2; beat++) begin
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    beats[beat]   = wr_req.data;
                    wr_rsp.strobe = 1'b1;
                    wr_rsp.last   = (beat == 1);
                    @(negedge clk);
                    wr_rsp = '0;
                end
                mem[line]                 = beats[0];
                mem[line + ADDR_W'(8)]    = beats[1];
            end
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        #((n_tests * 200 + RST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the cache stopped answering requests");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main
        logic ok;
        int   fails;
        rst     = 1'b1;
        cpu_req = '0;
        rd_rsp  = '0;
        wr_rsp  = '0;
        ok = read_trace();
        if (!ok) begin
            $display("trace file could not be read or has no counts line");
            $display("TEST FAILED");
            $finish;
        end else begin
            trace_loaded = 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            for (int i = 0; i < n_tests; i++) run_request(i);
            checker_inst.close_report(exp_hits, exp_misses, fails);
            if (fails == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sim/dcache_trace.txt
# name op(R load, W store) bytes addr(hex) wdata(hex) expect(hex, loads only)
# last line: counts <expected hits> <expected misses>
rd_miss_d R 8 00001050 0000000000000000 ffffefaf00001050
rd_hit_d R 8 00001050 0000000000000000 ffffefaf00001050
rd_hit_w R 4 0000105c 0000000000000000 00000000ffffefa7
rd_hit_b R 1 00001059 0000000000000000 0000000000000010
rd_miss_h R 2 00000224 0000000000000000 000000000000fddf
rd_miss_b R 1 0000033d 0000000000000000 00000000000000fc
wr_hit_b W 1 00001053 00000000000000a5 0000000000000000
wr_hit_h W 2 0000105a 000000000000beef 0000000000000000
rd_merge_lo R 8 00001050 0000000000000000 ffffefafa5001050
rd_merge_hi R 8 00001058 0000000000000000 ffffefa7beef1058
wr_miss_w W 4 00000444 0000000012345678 0000000000000000
rd_merge_w R 8 00000440 0000000000000000 1234567800000440
wr_miss_d W 8 00000558 0123456789abcdef 0000000000000000
rd_merge_b R 1 0000055e 0000000000000000 0000000000000023
rd_neighbor R 8 00000550 0000000000000000 fffffaaf00000550
fill_way1 R 4 00002054 0000000000000000 00000000ffffdfaf
fill_way2 R 2 0000305c 0000000000000000 000000000000cfa7
fill_way3 R 1 00004050 0000000000000000 0000000000000050
evict_dirty_wr W 8 00005058 0badc0defeedface 0000000000000000
reread_lo R 8 00001050 0000000000000000 ffffefafa5001050
reread_hi R 8 00001058 0000000000000000 ffffefa7beef1058
evict_clean R 4 00006054 0000000000000000 00000000ffff9faf
evict_dirty_rd R 8 00007050 0000000000000000 ffff8faf00007050
reread_wb_hi R 8 00005058 0000000000000000 0badc0defeedface
reread_wb_lo R 2 00005054 0000000000000000 000000000000afaf
counts 12 13
